// File: Bender.yml
package:
  name: xbar

export_include_dirs:
  - hw

sources:
  - hw/xbar_pkg.sv
  - hw/xbar_addr_decode.sv
  - hw/xbar_demux.sv
  - hw/xbar_mux.sv
  - hw/xbar_top.sv
  - target: simulation
    files:
      - sim/tb_xbar.sv

// File: all.f
+incdir+hw
hw/xbar_pkg.sv
hw/xbar_addr_decode.sv
hw/xbar_demux.sv
hw/xbar_mux.sv
hw/xbar_top.sv
sim/tb_xbar.sv

// File: hw/xbar_addr_decode.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module xbar_addr_decode import xbar_pkg::*; (
  input  addr_t                       addr_i,
  input  rule_t [`XBAR_NUM_RULES-1:0] addr_map_i,
  input  logic                        en_default_i,
  input  mgr_idx_t                    default_idx_i,
  output sel_t                        sel_o
);

  logic     match;
  mgr_idx_t match_idx;

  // Later rules override earlier ones, so the highest matching index wins
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int i = 0; i < `XBAR_NUM_RULES; i++) begin
      if ((addr_i >= addr_map_i[i].start_addr) && (addr_i < addr_map_i[i].end_addr)) begin
        match     = 1'b1;
        match_idx = addr_map_i[i].idx;
      end
    end
  end

  // Miss falls back to the default target or to the error path
  always_comb begin
    if (match) begin
      sel_o = sel_t'(match_idx);
    end else if (en_default_i) begin
      sel_o = sel_t'(default_idx_i);
    end else begin
      sel_o = SEL_DECERR;
    end
  end

  // A non-empty rule must point at an existing target port
  always_comb begin
    for (int i = 0; i < `XBAR_NUM_RULES; i++) begin
      if (addr_map_i[i].start_addr < addr_map_i[i].end_addr) begin
        assert (addr_map_i[i].idx < `XBAR_NUM_MGR)
          else $error("Rule %0d targets port %0d, which does not exist",
                      i, addr_map_i[i].idx);
      end
    end
  end

endmodule

// File: hw/xbar_cfg.svh
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// Number of requester-side ports
`define XBAR_NUM_SBR 2

// Number of target-side ports
`define XBAR_NUM_MGR 3

// Entries in the run-time address map
`define XBAR_NUM_RULES 4

// Bus widths
`define XBAR_ADDR_WIDTH 32
`define XBAR_DATA_WIDTH 32

`endif

// File: hw/xbar_demux.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module xbar_demux import xbar_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Requester ar channel
  input  logic                                ar_valid_i,
  output logic                                ar_ready_o,
  input  addr_t                               ar_addr_i,
  // Requester r channel
  output logic                                r_valid_o,
  input  logic                                r_ready_i,
  output data_t                               r_data_o,
  output resp_e                               r_resp_o,
  // Address map and default target
  input  rule_t    [`XBAR_NUM_RULES-1:0]      addr_map_i,
  input  logic                                en_default_i,
  input  mgr_idx_t                            default_idx_i,
  // Requests toward the target-side muxes
  output logic     [`XBAR_NUM_MGR-1:0]        req_valid_o,
  input  logic     [`XBAR_NUM_MGR-1:0]        req_ready_i,
  output addr_t                               req_addr_o,
  // Responses from the target-side muxes
  input  logic     [`XBAR_NUM_MGR-1:0]        rsp_valid_i,
  output logic     [`XBAR_NUM_MGR-1:0]        rsp_ready_o,
  input  data_t    [`XBAR_NUM_MGR-1:0]        rsp_data_i
);

  demux_state_e state_q, state_d;
  sel_t         sel_q;
  sel_t         dec_sel;
  addr_t        addr_q;
  mgr_idx_t     tgt;

  xbar_addr_decode u_addr_decode (
    .addr_i        (ar_addr_i),
    .addr_map_i    (addr_map_i),
    .en_default_i  (en_default_i),
    .default_idx_i (default_idx_i),
    .sel_o         (dec_sel)
  );

  assign tgt        = mgr_idx_t'(sel_q);
  assign ar_ready_o = (state_q == IDLE);
  assign req_addr_o = addr_q;

  always_comb begin
    state_d     = state_q;
    req_valid_o = '0;
    rsp_ready_o = '0;
    r_valid_o   = 1'b0;
    r_data_o    = '0;
    r_resp_o    = RESP_OKAY;
    case (state_q)
      IDLE: begin
        if (ar_valid_i) begin
          state_d = (dec_sel == SEL_DECERR) ? ERR_RESP : ROUTE;
        end
      end
      ROUTE: begin
        req_valid_o[tgt] = 1'b1;
        if (req_ready_i[tgt]) begin
          state_d = WAIT_RESP;
        end
      end
      WAIT_RESP: begin
        // Response of the selected target goes straight through
        r_valid_o        = rsp_valid_i[tgt];
        r_data_o         = rsp_data_i[tgt];
        rsp_ready_o[tgt] = r_ready_i;
        if (rsp_valid_i[tgt] && r_ready_i) begin
          state_d = IDLE;
        end
      end
      ERR_RESP: begin
        // Local error responder
        r_valid_o = 1'b1;
        r_resp_o  = RESP_DECERR;
        if (r_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      sel_q   <= '0;
    end else begin
      state_q <= state_d;
      if (ar_valid_i && ar_ready_o) begin
        sel_q <= dec_sel;
      end
    end
  end

  // Address payload, captured on accept
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      addr_q <= ar_addr_i;
    end
  end

  // The default target must not move under a pending request
  default_port_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (ar_valid_i && !ar_ready_o) |=> ($stable(en_default_i) && $stable(default_idx_i))
  ) else $error("Default target changed while an ar request was pending");

  req_onehot: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $onehot0(req_valid_o)
  ) else $error("Request raised toward more than one target");

endmodule

// File: hw/xbar_mux.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module xbar_mux import xbar_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Requests from the requester-side demuxes
  input  logic  [`XBAR_NUM_SBR-1:0]        req_valid_i,
  output logic  [`XBAR_NUM_SBR-1:0]        req_ready_o,
  input  addr_t [`XBAR_NUM_SBR-1:0]        req_addr_i,
  // Responses back to the demuxes
  output logic  [`XBAR_NUM_SBR-1:0]        rsp_valid_o,
  input  logic  [`XBAR_NUM_SBR-1:0]        rsp_ready_i,
  output data_t                            rsp_data_o,
  // Target ar channel
  output logic                             mgr_ar_valid_o,
  input  logic                             mgr_ar_ready_i,
  output addr_t                            mgr_ar_addr_o,
  // Target r channel
  input  logic                             mgr_r_valid_i,
  output logic                             mgr_r_ready_o,
  input  data_t                            mgr_r_data_i
);

  mux_state_e state_q, state_d;
  sbr_idx_t   rr_q, rr_d;
  sbr_idx_t   grant_q, grant_d;
  logic       lock_q, lock_d;
  sbr_idx_t   arb_idx;
  sbr_idx_t   sel_idx;

  // Round-robin search starting at the requester after the last grant
  always_comb begin
    logic     found;
    sbr_idx_t cand;
    found   = 1'b0;
    arb_idx = rr_q;
    for (int i = 0; i < `XBAR_NUM_SBR; i++) begin
      cand = sbr_idx_t'(rr_q + i);
      if (!found && req_valid_i[cand]) begin
        found   = 1'b1;
        arb_idx = cand;
      end
    end
  end

  // Once offered to the target, the choice is held until accepted
  assign sel_idx       = lock_q ? grant_q : arb_idx;
  assign mgr_ar_addr_o = req_addr_i[sel_idx];
  assign rsp_data_o    = mgr_r_data_i;

  always_comb begin
    state_d        = state_q;
    rr_d           = rr_q;
    grant_d        = grant_q;
    lock_d         = lock_q;
    req_ready_o    = '0;
    rsp_valid_o    = '0;
    mgr_ar_valid_o = 1'b0;
    mgr_r_ready_o  = 1'b0;
    case (state_q)
      ARB: begin
        mgr_ar_valid_o       = req_valid_i[sel_idx];
        req_ready_o[sel_idx] = mgr_ar_ready_i;
        if (req_valid_i[sel_idx]) begin
          grant_d = sel_idx;
          if (mgr_ar_ready_i) begin
            state_d = BUSY;
            lock_d  = 1'b0;
            rr_d    = sbr_idx_t'(sel_idx + 1'b1);
          end else begin
            lock_d = 1'b1;
          end
        end
      end
      BUSY: begin
        // Only the granted demux sees the target response
        rsp_valid_o[grant_q] = mgr_r_valid_i;
        mgr_r_ready_o        = rsp_ready_i[grant_q];
        if (mgr_r_valid_i && rsp_ready_i[grant_q]) begin
          state_d = ARB;
        end
      end
      default: state_d = ARB;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ARB;
      rr_q    <= '0;
      grant_q <= '0;
      lock_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      rr_q    <= rr_d;
      grant_q <= grant_d;
      lock_q  <= lock_d;
    end
  end

  rsp_to_grant_only: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (|rsp_valid_o) |-> (state_q == BUSY) && (rsp_valid_o == (`XBAR_NUM_SBR'(1) << grant_q))
  ) else $error("Response steered to a requester that does not hold the grant");

  // Target sees a stable address while its ar is stalled
  ar_addr_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (mgr_ar_valid_o && !mgr_ar_ready_i) |=> (mgr_ar_valid_o && $stable(mgr_ar_addr_o))
  ) else $error("Target ar request dropped or changed before acceptance");

endmodule

// File: hw/xbar_pkg.sv
`include "xbar_cfg.svh"

package xbar_pkg;

  typedef logic [`XBAR_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`XBAR_DATA_WIDTH-1:0] data_t;

  // Target port number
  typedef logic [1:0] mgr_idx_t;

  // Routing choice, targets 0 to 2 plus the decode-error path
  typedef logic [1:0] sel_t;

  // Requester port number
  typedef logic sbr_idx_t;

  // Routing choice that selects the local error responder
  localparam sel_t SEL_DECERR = sel_t'(`XBAR_NUM_MGR);

  // One address rule, end address is exclusive
  typedef struct packed {
    mgr_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } rule_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_DECERR = 2'd3
  } resp_e;

  typedef enum logic [1:0] {IDLE, ROUTE, WAIT_RESP, ERR_RESP} demux_state_e;

  typedef enum logic {ARB, BUSY} mux_state_e;

endpackage

// File: hw/xbar_top.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module xbar_top import xbar_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Requester ports
  input  logic     [`XBAR_NUM_SBR-1:0]        sbr_ar_valid_i,
  output logic     [`XBAR_NUM_SBR-1:0]        sbr_ar_ready_o,
  input  addr_t    [`XBAR_NUM_SBR-1:0]        sbr_ar_addr_i,
  output logic     [`XBAR_NUM_SBR-1:0]        sbr_r_valid_o,
  input  logic     [`XBAR_NUM_SBR-1:0]        sbr_r_ready_i,
  output data_t    [`XBAR_NUM_SBR-1:0]        sbr_r_data_o,
  output resp_e    [`XBAR_NUM_SBR-1:0]        sbr_r_resp_o,
  // Target ports
  output logic     [`XBAR_NUM_MGR-1:0]        mgr_ar_valid_o,
  input  logic     [`XBAR_NUM_MGR-1:0]        mgr_ar_ready_i,
  output addr_t    [`XBAR_NUM_MGR-1:0]        mgr_ar_addr_o,
  input  logic     [`XBAR_NUM_MGR-1:0]        mgr_r_valid_i,
  output logic     [`XBAR_NUM_MGR-1:0]        mgr_r_ready_o,
  input  data_t    [`XBAR_NUM_MGR-1:0]        mgr_r_data_i,
  // Configuration
  input  rule_t    [`XBAR_NUM_RULES-1:0]      addr_map_i,
  input  logic     [`XBAR_NUM_SBR-1:0]        en_default_mgr_port_i,
  input  mgr_idx_t [`XBAR_NUM_SBR-1:0]        default_mgr_port_i
);

  // Demux view is [s][m], mux view is [m][s]
  logic  [`XBAR_NUM_SBR-1:0][`XBAR_NUM_MGR-1:0] req_valid;
  logic  [`XBAR_NUM_MGR-1:0][`XBAR_NUM_SBR-1:0] req_valid_t;
  logic  [`XBAR_NUM_MGR-1:0][`XBAR_NUM_SBR-1:0] req_ready;
  logic  [`XBAR_NUM_SBR-1:0][`XBAR_NUM_MGR-1:0] req_ready_t;
  addr_t [`XBAR_NUM_SBR-1:0]                    req_addr;
  logic  [`XBAR_NUM_MGR-1:0][`XBAR_NUM_SBR-1:0] rsp_valid;
  logic  [`XBAR_NUM_SBR-1:0][`XBAR_NUM_MGR-1:0] rsp_valid_t;
  logic  [`XBAR_NUM_SBR-1:0][`XBAR_NUM_MGR-1:0] rsp_ready;
  logic  [`XBAR_NUM_MGR-1:0][`XBAR_NUM_SBR-1:0] rsp_ready_t;
  data_t [`XBAR_NUM_MGR-1:0]                    rsp_data;

  for (genvar s = 0; s < `XBAR_NUM_SBR; s++) begin : gen_cross_sbr
    for (genvar m = 0; m < `XBAR_NUM_MGR; m++) begin : gen_cross_mgr
      assign req_valid_t[m][s] = req_valid[s][m];
      assign req_ready_t[s][m] = req_ready[m][s];
      assign rsp_valid_t[s][m] = rsp_valid[m][s];
      assign rsp_ready_t[m][s] = rsp_ready[s][m];
    end
  end

  for (genvar s = 0; s < `XBAR_NUM_SBR; s++) begin : gen_demux
    xbar_demux u_demux (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .ar_valid_i    (sbr_ar_valid_i[s]),
      .ar_ready_o    (sbr_ar_ready_o[s]),
      .ar_addr_i     (sbr_ar_addr_i[s]),
      .r_valid_o     (sbr_r_valid_o[s]),
      .r_ready_i     (sbr_r_ready_i[s]),
      .r_data_o      (sbr_r_data_o[s]),
      .r_resp_o      (sbr_r_resp_o[s]),
      .addr_map_i    (addr_map_i),
      .en_default_i  (en_default_mgr_port_i[s]),
      .default_idx_i (default_mgr_port_i[s]),
      .req_valid_o   (req_valid[s]),
      .req_ready_i   (req_ready_t[s]),
      .req_addr_o    (req_addr[s]),
      .rsp_valid_i   (rsp_valid_t[s]),
      .rsp_ready_o   (rsp_ready[s]),
      .rsp_data_i    (rsp_data)
    );
  end

  for (genvar m = 0; m < `XBAR_NUM_MGR; m++) begin : gen_mux
    xbar_mux u_mux (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .req_valid_i    (req_valid_t[m]),
      .req_ready_o    (req_ready[m]),
      .req_addr_i     (req_addr),
      .rsp_valid_o    (rsp_valid[m]),
      .rsp_ready_i    (rsp_ready_t[m]),
      .rsp_data_o     (rsp_data[m]),
      .mgr_ar_valid_o (mgr_ar_valid_o[m]),
      .mgr_ar_ready_i (mgr_ar_ready_i[m]),
      .mgr_ar_addr_o  (mgr_ar_addr_o[m]),
      .mgr_r_valid_i  (mgr_r_valid_i[m]),
      .mgr_r_ready_o  (mgr_r_ready_o[m]),
      .mgr_r_data_i   (mgr_r_data_i[m])
    );
  end

endmodule

// File: sim/tb_xbar.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module tb_xbar import xbar_pkg::*; ();

  localparam int NS = `XBAR_NUM_SBR;
  localparam int NM = `XBAR_NUM_MGR;
  localparam int NR = `XBAR_NUM_RULES;

  // Requests per phase for the directed map, default target, hammer and random tests
  localparam int NUM_REQS   = 12 + 6 + 16 + 64;
  localparam int MAX_CYCLES = 20 * NUM_REQS + 50;

  // Each target answers with the address XOR its own tag
  localparam data_t TGT_TAG [NM] = '{32'hA5A5_0000, 32'h5A5A_1111, 32'hC3C3_2222};

  typedef struct packed {
    logic     err;
    mgr_idx_t tgt;
    resp_e    resp;
    data_t    data;
  } expect_t;

  logic                clk_i;
  logic                rst_i;
  logic     [NS-1:0]   sbr_ar_valid_i;
  logic     [NS-1:0]   sbr_ar_ready_o;
  addr_t    [NS-1:0]   sbr_ar_addr_i;
  logic     [NS-1:0]   sbr_r_valid_o;
  logic     [NS-1:0]   sbr_r_ready_i;
  data_t    [NS-1:0]   sbr_r_data_o;
  resp_e    [NS-1:0]   sbr_r_resp_o;
  logic     [NM-1:0]   mgr_ar_valid_o;
  logic     [NM-1:0]   mgr_ar_ready_i;
  addr_t    [NM-1:0]   mgr_ar_addr_o;
  logic     [NM-1:0]   mgr_r_valid_i;
  logic     [NM-1:0]   mgr_r_ready_o;
  data_t    [NM-1:0]   mgr_r_data_i;
  rule_t    [NR-1:0]   addr_map_i;
  logic     [NS-1:0]   en_default_mgr_port_i;
  mgr_idx_t [NS-1:0]   default_mgr_port_i;

  integer  seed;
  logic    eager;
  addr_t   req_q [NS][$];
  int      queued_cnt;
  int      done_cnt;
  int      cycle_cnt = 0;
  // One outstanding read per requester
  logic    [NS-1:0] pend_valid;
  logic    [NS-1:0] pend_fwd;
  logic    [NS-1:0] ar_done;
  addr_t   pend_addr [NS];
  expect_t pend_exp [NS];
  // Target model state is 0 when idle, 1 while waiting out the delay and 2 while responding
  int      tgt_state [NM];
  int      tgt_delay [NM];
  addr_t   tgt_addr [NM];

  xbar_top u_xbar_top (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .sbr_ar_valid_i        (sbr_ar_valid_i),
    .sbr_ar_ready_o        (sbr_ar_ready_o),
    .sbr_ar_addr_i         (sbr_ar_addr_i),
    .sbr_r_valid_o         (sbr_r_valid_o),
    .sbr_r_ready_i         (sbr_r_ready_i),
    .sbr_r_data_o          (sbr_r_data_o),
    .sbr_r_resp_o          (sbr_r_resp_o),
    .mgr_ar_valid_o        (mgr_ar_valid_o),
    .mgr_ar_ready_i        (mgr_ar_ready_i),
    .mgr_ar_addr_o         (mgr_ar_addr_o),
    .mgr_r_valid_i         (mgr_r_valid_i),
    .mgr_r_ready_o         (mgr_r_ready_o),
    .mgr_r_data_i          (mgr_r_data_i),
    .addr_map_i            (addr_map_i),
    .en_default_mgr_port_i (en_default_mgr_port_i),
    .default_mgr_port_i    (default_mgr_port_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic end_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_fault(input string msg);
    $display("Error: %s", msg);
    end_with_failure();
  endtask

  task automatic compare_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic compare_resp(input string name, input resp_e got, input resp_e exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      end_with_failure();
    end
  endtask

  function automatic logic random_bit();
    return ($random(seed) & 1) != 0;
  endfunction

  // Expected outcome from the map rules, scanning down so the highest match wins
  function automatic expect_t expected_result(input addr_t addr, input rule_t [NR-1:0] map,
                                              input logic en_def, input mgr_idx_t def_idx);
    expect_t r;
    logic    hit;
    hit   = 1'b0;
    r.tgt = '0;
    for (int i = NR - 1; i >= 0; i--) begin
      if (!hit && addr >= map[i].start_addr && addr < map[i].end_addr) begin
        hit   = 1'b1;
        r.tgt = map[i].idx;
      end
    end
    if (!hit && en_def) begin
      hit   = 1'b1;
      r.tgt = def_idx;
    end
    r.err  = !hit;
    r.resp = hit ? RESP_OKAY : RESP_DECERR;
    r.data = hit ? (addr ^ TGT_TAG[r.tgt]) : '0;
    return r;
  endfunction

  task automatic queue_request(input int s, input addr_t addr);
    req_q[s].push_back(addr);
    queued_cnt++;
  endtask

  // Wait until every queued request has been answered
  task automatic drain_traffic();
    @(posedge clk_i);
    while (req_q[0].size() != 0 || req_q[1].size() != 0 || sbr_ar_valid_i != '0 ||
           done_cnt != queued_cnt) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  // Requester and target drivers run on the falling edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      for (int s = 0; s < NS; s++) begin
        if (ar_done[s]) begin
          sbr_ar_valid_i[s] = 1'b0;
          ar_done[s]        = 1'b0;
        end
        if (!sbr_ar_valid_i[s] && req_q[s].size() != 0 && (eager || random_bit())) begin
          sbr_ar_addr_i[s]  = req_q[s].pop_front();
          sbr_ar_valid_i[s] = 1'b1;
        end
        sbr_r_ready_i[s] = random_bit();
      end
      for (int m = 0; m < NM; m++) begin
        if (tgt_state[m] == 0) begin
          mgr_ar_ready_i[m] = random_bit();
          mgr_r_valid_i[m]  = 1'b0;
        end else if (tgt_state[m] == 1) begin
          mgr_ar_ready_i[m] = 1'b0;
          if (tgt_delay[m] == 0) begin
            mgr_r_valid_i[m] = 1'b1;
            mgr_r_data_i[m]  = tgt_addr[m] ^ TGT_TAG[m];
            tgt_state[m]     = 2;
          end else begin
            tgt_delay[m]--;
          end
        end
      end
    end
  end

  // Scoreboard records accepted requests and checks every handshake
  always @(posedge clk_i) begin
    logic match;
    if (!rst_i) begin
      for (int s = 0; s < NS; s++) begin
        if (sbr_r_valid_o[s] && sbr_r_ready_i[s]) begin
          if (!pend_valid[s]) begin
            report_fault($sformatf("requester %0d got a response with no read outstanding", s));
          end
          if (!pend_exp[s].err && !pend_fwd[s]) begin
            report_fault($sformatf("requester %0d got a response before any target saw it", s));
          end
          compare_data($sformatf("sbr_r_data_o[%0d]", s), sbr_r_data_o[s], pend_exp[s].data);
          compare_resp($sformatf("sbr_r_resp_o[%0d]", s), sbr_r_resp_o[s], pend_exp[s].resp);
          pend_valid[s] = 1'b0;
          done_cnt++;
        end
      end
      for (int m = 0; m < NM; m++) begin
        if (mgr_ar_valid_o[m]) begin
          match = 1'b0;
          for (int s = 0; s < NS; s++) begin
            if (!match && pend_valid[s] && !pend_fwd[s] && !pend_exp[s].err &&
                pend_exp[s].tgt == mgr_idx_t'(m) && pend_addr[s] == mgr_ar_addr_o[m]) begin
              match = 1'b1;
              if (mgr_ar_ready_i[m]) begin
                pend_fwd[s] = 1'b1;
              end
            end
          end
          if (!match) begin
            report_fault($sformatf("target %0d saw address 0x%h that no pending read routes there",
                                   m, mgr_ar_addr_o[m]));
          end
          if (mgr_ar_ready_i[m] && tgt_state[m] == 0) begin
            tgt_state[m] = 1;
            tgt_addr[m]  = mgr_ar_addr_o[m];
            tgt_delay[m] = {$random(seed)} % 4;
          end
        end
        if (mgr_r_valid_i[m] && mgr_r_ready_o[m] && tgt_state[m] == 2) begin
          tgt_state[m] = 0;
        end
      end
      for (int s = 0; s < NS; s++) begin
        if (sbr_ar_valid_i[s] && sbr_ar_ready_o[s]) begin
          if (pend_valid[s]) begin
            report_fault($sformatf("requester %0d accepted a second read while one was open", s));
          end
          pend_valid[s] = 1'b1;
          pend_fwd[s]   = 1'b0;
          pend_addr[s]  = sbr_ar_addr_i[s];
          pend_exp[s]   = expected_result(sbr_ar_addr_i[s], addr_map_i,
                                          en_default_mgr_port_i[s], default_mgr_port_i[s]);
          ar_done[s]    = 1'b1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      report_fault($sformatf("timeout after %0d cycles, %0d of %0d reads answered",
                             cycle_cnt, done_cnt, NUM_REQS));
    end
  end

  initial begin
    seed                  = 32'h9017_76b8;
    rst_i                 = 1'b1;
    sbr_ar_valid_i        = '0;
    sbr_ar_addr_i         = '0;
    sbr_r_ready_i         = '0;
    mgr_ar_ready_i        = '0;
    mgr_r_valid_i         = '0;
    mgr_r_data_i          = '0;
    en_default_mgr_port_i = '0;
    default_mgr_port_i    = '0;
    eager                 = 1'b0;
    queued_cnt            = 0;
    done_cnt              = 0;
    pend_valid            = '0;
    pend_fwd              = '0;
    ar_done               = '0;
    for (int m = 0; m < NM; m++) begin
      tgt_state[m] = 0;
      tgt_delay[m] = 0;
      tgt_addr[m]  = '0;
    end
    // Rule 3 overlaps rules 1 and 2 and wins over both
    addr_map_i[0] = '{idx: 2'd0, start_addr: 32'h0000_0000, end_addr: 32'h1000_0000};
    addr_map_i[1] = '{idx: 2'd1, start_addr: 32'h1000_0000, end_addr: 32'h2000_0000};
    addr_map_i[2] = '{idx: 2'd2, start_addr: 32'h2000_0000, end_addr: 32'h3000_0000};
    addr_map_i[3] = '{idx: 2'd0, start_addr: 32'h1800_0000, end_addr: 32'h2800_0000};
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Mapped addresses on all targets plus decode errors
    queue_request(0, 32'h0000_0100);
    queue_request(0, 32'h1000_0200);
    queue_request(0, 32'h2800_0300);
    queue_request(0, 32'h1800_0040);
    queue_request(0, 32'h27ff_fffc);
    queue_request(0, 32'h4000_0000);
    queue_request(1, 32'h2000_0010);
    queue_request(1, 32'h0fff_fffc);
    queue_request(1, 32'h1fff_fff0);
    queue_request(1, 32'h17ff_fff8);
    queue_request(1, 32'h3000_0000);
    queue_request(1, 32'hffff_fff0);
    drain_traffic();

    // Misses go to the default target
    en_default_mgr_port_i = 2'b11;
    default_mgr_port_i[0] = 2'd2;
    default_mgr_port_i[1] = 2'd1;
    queue_request(0, 32'h3000_0004);
    queue_request(0, 32'h8000_0000);
    queue_request(0, 32'h0000_0040);
    queue_request(1, 32'h5000_0000);
    queue_request(1, 32'hc000_0010);
    queue_request(1, 32'h2900_0000);
    drain_traffic();

    // Both requesters on target 2 back to back
    eager = 1'b1;
    for (int i = 0; i < 8; i++) begin
      queue_request(0, 32'h2c00_0000 + addr_t'(i * 4));
      queue_request(1, 32'h2c00_1000 + addr_t'(i * 4));
    end
    drain_traffic();

    // Random traffic with random default settings
    eager = 1'b0;
    for (int s = 0; s < NS; s++) begin
      en_default_mgr_port_i[s] = random_bit();
      default_mgr_port_i[s]    = mgr_idx_t'({$random(seed)} % NM);
    end
    for (int i = 0; i < 32; i++) begin
      queue_request(0, {2'b00, 30'($random(seed))});
      queue_request(1, {2'b00, 30'($random(seed))});
    end
    drain_traffic();

    if (done_cnt == NUM_REQS && pend_valid == '0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      report_fault($sformatf("only %0d of %0d reads were answered", done_cnt, NUM_REQS));
    end
  end

endmodule
